// File: dv/cache_tb.sv
`timescale 1ns/10ps

module cache_tb
    import cache_pkg::*;
();

    localparam int ack_timeout  = 400;
    localparam int idle_timeout = 200;
    localparam int hit_latency  = 3;

    typedef struct packed {
        logic       is_write;
        byte_addr_t addr;
        byte_t      wdata;
        logic       sdram_expected;
    } stim_t;

    logic        sys_clk;
    logic        reset_n;
    byte_addr_t  address;
    byte_t       data_write;
    logic        read_req;
    logic        write_req;
    byte_t       data_read;
    logic        read_ack;
    logic        write_ack;
    sdram_addr_t sdram_address;
    word_t       sdram_data_write;
    word_t       sdram_data_read;
    logic        sdram_read_req;
    logic        sdram_write_req;
    logic        sdram_read_ack;
    logic        sdram_write_ack;
    int          words_written;

    stim_t                 stim [$];
    byte_t                 shadow [2**17];
    tag_t                  model_tag [cache_ways][cache_sets];
    logic [cache_sets-1:0] model_valid [cache_ways];
    logic [cache_sets-1:0] model_dirty [cache_ways];
    logic [cache_sets-1:0] model_mru;

    int   fetch_count      = 0;
    int   write_back_count = 0;
    logic read_req_seen    = 1'b0;
    logic write_req_seen   = 1'b0;
    int   value_errors     = 0;
    int   latency_errors   = 0;
    int   transfer_errors  = 0;
    int   timeouts         = 0;
    logic aborted          = 1'b0;

    tb_clock_gen clk0 (
        .sys_clk (sys_clk),
        .reset_n (reset_n)
    );

    cache_top dut0 (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .address          (address),
        .data_write       (data_write),
        .read_req         (read_req),
        .write_req        (write_req),
        .data_read        (data_read),
        .read_ack         (read_ack),
        .write_ack        (write_ack),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack)
    );

    sdram_model sdram0 (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack),
        .words_written    (words_written)
    );

    // line fetches and write-backs are counted on the request edges.
    always @(negedge sys_clk) begin
        if (sdram_read_req && !read_req_seen) begin
            fetch_count++;
        end
        if (sdram_write_req && !write_req_seen) begin
            write_back_count++;
        end
        read_req_seen  = sdram_read_req;
        write_req_seen = sdram_write_req;
    end

    function automatic byte_addr_t byte_addr(input tag_t tag, input set_index_t set_idx,
                                             input word_offset_t word, input logic lower);
        return {tag, set_idx, word, lower};
    endfunction

    task automatic add_entry(input logic is_write, input byte_addr_t addr, input byte_t wdata,
                             input logic sdram_expected);
        stim_t e;
        e.is_write       = is_write;
        e.addr           = addr;
        e.wdata          = wdata;
        e.sdram_expected = sdram_expected;
        stim.push_back(e);
    endtask

    // ------------------------------------------------------------
    // two-way tag model with the LRU victim rule
    // ------------------------------------------------------------
    task automatic predict_access(input stim_t s, output logic hit, output logic write_back,
                                  output byte_addr_t victim_base);
        set_index_t set_idx;
        tag_t       tag;
        way_t       way;
        set_idx     = s.addr[8:5];
        tag         = s.addr[16:9];
        hit         = 1'b0;
        write_back  = 1'b0;
        victim_base = '0;
        way         = 1'b0;
        for (int w = 0; w < cache_ways; w++) begin
            if (model_valid[w][set_idx] && model_tag[w][set_idx] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            if (!model_valid[0][set_idx]) begin
                way = 1'b0;
            end else if (!model_valid[1][set_idx]) begin
                way = 1'b1;
            end else begin
                way = ~model_mru[set_idx];
            end
            if (model_valid[way][set_idx] && model_dirty[way][set_idx]) begin
                write_back  = 1'b1;
                victim_base = {model_tag[way][set_idx], set_idx, 5'd0};
            end
            model_valid[way][set_idx] = 1'b1;
            model_dirty[way][set_idx] = 1'b0;
            model_tag[way][set_idx]   = tag;
        end
        model_mru[set_idx] = way;
        if (s.is_write) begin
            model_dirty[way][set_idx] = 1'b1;
        end
    endtask

    // a written-back line must match the shadow bytes word for word.
    task automatic check_line_in_sdram(input byte_addr_t base);
        byte_addr_t b;
        word_t      expected;
        word_t      actual;
        for (int w = 0; w < line_words; w++) begin
            b        = base + byte_addr_t'(2 * w);
            expected = {shadow[{b[16:1], 1'b0}], shadow[{b[16:1], 1'b1}]};
            actual   = sdram0.mem[b[16:1]];
            assert (actual == expected) else begin
                value_errors++;
                $display("FAIL %0t ns sdram word %h expected %h got %h",
                         $time, b[16:1], expected, actual);
            end
        end
    endtask

    task automatic run_entry(input int idx, input stim_t s);
        logic       hit;
        logic       write_back;
        byte_addr_t victim_base;
        int         fetch_before;
        int         wb_before;
        int         words_before;
        int         cycles;
        logic       acked;
        logic       transfer_seen;
        byte_t      expected;
        string      ack_name;

        predict_access(s, hit, write_back, victim_base);
        fetch_before = fetch_count;
        wb_before    = write_back_count;
        words_before = words_written;
        expected     = shadow[s.addr];
        ack_name     = s.is_write ? "write_ack" : "read_ack";

        @(posedge sys_clk);
        #1;
        address    = s.addr;
        data_write = s.wdata;
        read_req   = !s.is_write;
        write_req  = s.is_write;

        cycles = 0;
        acked  = 1'b0;
        while (!acked && cycles < ack_timeout) begin
            @(posedge sys_clk);
            #1;
            read_req  = 1'b0;
            write_req = 1'b0;
            cycles++;
            acked = s.is_write ? write_ack : read_ack;
        end
        if (!acked) begin
            timeouts++;
            aborted = 1'b1;
            $display("entry %0d got no %s within %0d cycles", idx, ack_name, ack_timeout);
            return;
        end

        if (s.is_write) begin
            shadow[s.addr] = s.wdata;
        end else begin
            assert (data_read == expected) else begin
                value_errors++;
                $display("FAIL %0t ns data_read expected %h got %h", $time, expected, data_read);
            end
        end
        if (hit) begin
            assert (cycles == hit_latency) else begin
                latency_errors++;
                $display("FAIL %0t ns %s latency expected %0d got %0d",
                         $time, ack_name, hit_latency, cycles);
            end
        end

        // a read miss acknowledges during the fill, and the line has to finish first.
        cycles = 0;
        while ((sdram_read_req || sdram_write_req) && cycles < idle_timeout) begin
            @(posedge sys_clk);
            #1;
            cycles++;
        end
        if (sdram_read_req || sdram_write_req) begin
            timeouts++;
            aborted = 1'b1;
            $display("entry %0d left an SDRAM request open for %0d cycles", idx, idle_timeout);
            return;
        end

        transfer_seen = (fetch_count != fetch_before) || (write_back_count != wb_before);
        assert (fetch_count - fetch_before == (hit ? 0 : 1)) else begin
            transfer_errors++;
            $display("FAIL %0t ns sdram_read_req edges expected %0d got %0d",
                     $time, hit ? 0 : 1, fetch_count - fetch_before);
        end
        assert (write_back_count - wb_before == (write_back ? 1 : 0)) else begin
            transfer_errors++;
            $display("FAIL %0t ns sdram_write_req edges expected %0d got %0d",
                     $time, write_back ? 1 : 0, write_back_count - wb_before);
        end
        assert (words_written - words_before == (write_back ? line_words : 0)) else begin
            transfer_errors++;
            $display("FAIL %0t ns sdram_write_ack words expected %0d got %0d",
                     $time, write_back ? line_words : 0, words_written - words_before);
        end
        assert (transfer_seen == s.sdram_expected) else begin
            transfer_errors++;
            $display("FAIL %0t ns sdram transfer expected %b got %b",
                     $time, s.sdram_expected, transfer_seen);
        end
        if (write_back) begin
            check_line_in_sdram(victim_base);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus table and main sequence
    // ------------------------------------------------------------
    initial begin
        int cycles;

        address    = '0;
        data_write = '0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        for (int b = 0; b < 2**17; b++) begin
            shadow[b] = b[0] ? ~b[8:1] : b[8:1];
        end
        model_valid = '{default: '0};
        model_dirty = '{default: '0};
        model_mru   = '0;

        // set 3 covers the cold miss, hits, and eviction of a dirty then a clean line.
        add_entry(1'b0, byte_addr(8'h01, 4'd3, 4'd5, 1'b1), 8'h00, 1'b1);
        add_entry(1'b0, byte_addr(8'h01, 4'd3, 4'd5, 1'b0), 8'h00, 1'b0);
        add_entry(1'b1, byte_addr(8'h01, 4'd3, 4'd5, 1'b1), 8'ha5, 1'b0);
        add_entry(1'b0, byte_addr(8'h01, 4'd3, 4'd5, 1'b1), 8'h00, 1'b0);
        add_entry(1'b0, byte_addr(8'h02, 4'd3, 4'd0, 1'b0), 8'h00, 1'b1);
        add_entry(1'b0, byte_addr(8'h03, 4'd3, 4'd7, 1'b1), 8'h00, 1'b1);
        add_entry(1'b0, byte_addr(8'h01, 4'd3, 4'd5, 1'b1), 8'h00, 1'b1);
        // set 9 runs A, B, A, C and then checks that B was the one evicted.
        add_entry(1'b1, byte_addr(8'h10, 4'd9, 4'd2, 1'b0), 8'h3c, 1'b1);
        add_entry(1'b0, byte_addr(8'h11, 4'd9, 4'd15, 1'b1), 8'h00, 1'b1);
        add_entry(1'b0, byte_addr(8'h10, 4'd9, 4'd2, 1'b0), 8'h00, 1'b0);
        add_entry(1'b0, byte_addr(8'h12, 4'd9, 4'd9, 1'b0), 8'h00, 1'b1);
        add_entry(1'b0, byte_addr(8'h10, 4'd9, 4'd2, 1'b1), 8'h00, 1'b0);
        add_entry(1'b0, byte_addr(8'h11, 4'd9, 4'd0, 1'b0), 8'h00, 1'b1);
        add_entry(1'b1, byte_addr(8'h20, 4'd9, 4'd4, 1'b1), 8'h77, 1'b1);
        add_entry(1'b0, byte_addr(8'h20, 4'd9, 4'd4, 1'b1), 8'h00, 1'b0);
        add_entry(1'b0, byte_addr(8'h30, 4'd0, 4'd15, 1'b0), 8'h00, 1'b1);
        add_entry(1'b1, byte_addr(8'h30, 4'd0, 4'd15, 1'b1), 8'hc3, 1'b0);
        add_entry(1'b0, byte_addr(8'h30, 4'd0, 4'd15, 1'b1), 8'h00, 1'b0);

        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 10) begin
            @(posedge sys_clk);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            timeouts++;
            aborted = 1'b1;
            $display("reset_n was never released");
        end

        for (int i = 0; i < stim.size(); i++) begin
            if (aborted) begin
                break;
            end
            run_entry(i, stim[i]);
        end

        $display("errors: %0d value, %0d latency, %0d transfer, %0d timeout",
                 value_errors, latency_errors, transfer_errors, timeouts);
        if (value_errors + latency_errors + transfer_errors + timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: dv/sdram_model.sv
`timescale 1ns/10ps

module sdram_model
    import cache_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset_n,
    input  sdram_addr_t sdram_address,
    input  word_t       sdram_data_write,
    output word_t       sdram_data_read,
    input  logic        sdram_read_req,
    input  logic        sdram_write_req,
    output logic        sdram_read_ack,
    output logic        sdram_write_ack,
    output int          words_written
);

    word_t       mem [65536];
    logic [31:0] lfsr = 32'h91be;
    logic [1:0]  gap;
    logic [1:0]  gap_bits;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // word A holds its low address byte on top and the inverse below.
    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = {a[7:0], ~a[7:0]};
        end
        sdram_read_ack  <= 1'b0;
        sdram_write_ack <= 1'b0;
        sdram_data_read <= '0;
        words_written   <= 0;
    end

    // ------------------------------------------------------------
    // one acknowledge at a time, never two edges in a row
    // ------------------------------------------------------------
    always @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            sdram_read_ack  <= 1'b0;
            sdram_write_ack <= 1'b0;
            gap             <= 2'd0;
            words_written   <= 0;
        end else begin
            sdram_read_ack  <= 1'b0;
            sdram_write_ack <= 1'b0;
            if (sdram_write_ack) begin
                // the controller steps its address at this edge, so the word is taken now.
                mem[sdram_address[15:0]] = sdram_data_write;
                words_written <= words_written + 1;
            end
            if (sdram_read_ack || sdram_write_ack) begin
                lfsr        = lfsr_step(lfsr);
                gap_bits[0] = lfsr[0];
                lfsr        = lfsr_step(lfsr);
                gap_bits[1] = lfsr[0];
                gap <= gap_bits;
            end else if (gap != 2'd0) begin
                gap <= gap - 2'd1;
            end else if (sdram_read_req) begin
                sdram_read_ack  <= 1'b1;
                sdram_data_read <= mem[sdram_address[15:0]];
            end else if (sdram_write_req) begin
                sdram_write_ack <= 1'b1;
            end
        end
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic sys_clk,
    output logic reset_n
);

    localparam real half_period = 2.0;

    initial begin
        sys_clk = 1'b0;
        forever #half_period sys_clk = ~sys_clk;
    end

    // reset is held across three rising edges.
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge sys_clk);
        #1 reset_n = 1'b1;
    end

endmodule

// File: flist.f
verilog/cache_pkg.sv
verilog/cache_tag_store.sv
verilog/cache_way_ram.sv
verilog/cache_controller.sv
verilog/cache_top.sv
dv/tb_clock_gen.sv
dv/sdram_model.sv
dv/cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f flist.f \
    && ./obj_dir/Vcache_tb | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verilog/cache_controller.sv
`timescale 1ns/10ps

module cache_controller
    import cache_pkg::*;
(
    input  logic                  sys_clk,
    input  logic                  reset_n,
    input  byte_addr_t            address,
    input  byte_t                 data_write,
    input  logic                  read_req,
    input  logic                  write_req,
    output byte_t                 data_read,
    output logic                  read_ack,
    output logic                  write_ack,
    output sdram_addr_t           sdram_address,
    output word_t                 sdram_data_write,
    input  word_t                 sdram_data_read,
    output logic                  sdram_read_req,
    output logic                  sdram_write_req,
    input  logic                  sdram_read_ack,
    input  logic                  sdram_write_ack,
    output set_index_t            lookup_set,
    output tag_t                  lookup_tag,
    input  tag_lookup_t           lookup,
    output tag_update_t           update,
    output way_ram_req_t          ram_req,
    output logic [cache_ways-1:0] ram_wr_en,
    input  word_t                 ram_q [cache_ways]
);

    ctrl_state_t  state;
    byte_addr_t   addr_r;
    logic         op_write;
    way_t         way_r;
    tag_t         victim_tag_r;
    word_offset_t beat;
    word_offset_t req_word;
    logic         wb_beat;
    logic         fill_beat;
    logic         last_beat;

    function automatic byte_t pick_byte(input word_t w, input logic lower);
        return lower ? w[7:0] : w[15:8];
    endfunction

    // the address is held for the whole transaction, since a read miss acks mid-fill.
    assign lookup_set = addr_r[8:5];
    assign lookup_tag = addr_r[16:9];
    assign req_word   = addr_r[4:1];

    assign wb_beat   = (state == st_write_back) && sdram_write_ack;
    assign fill_beat = (state == st_fill) && sdram_read_ack;
    assign last_beat = (beat == word_offset_t'(line_words - 1));

    assign sdram_data_write = ram_q[way_r];

    // ------------------------------------------------------------
    // way RAM and tag store requests
    // ------------------------------------------------------------
    always_comb begin
        ram_req.addr    = {lookup_set, req_word};
        ram_req.wdata   = {data_write, data_write};
        ram_req.byte_en = addr_r[0] ? 2'b01 : 2'b10;
        ram_wr_en       = '0;
        case (state)
            st_evict_rd, st_write_back: begin
                // step ahead on an acknowledge so that q holds the next word one cycle later.
                ram_req.addr = {lookup_set, beat + word_offset_t'(wb_beat)};
            end
            st_fill: begin
                ram_req.addr     = {lookup_set, beat};
                ram_req.wdata    = sdram_data_read;
                ram_req.byte_en  = 2'b11;
                ram_wr_en[way_r] = sdram_read_ack;
            end
            st_hit_write, st_alloc_write: begin
                ram_wr_en[way_r] = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        update     = '0;
        update.way = way_r;
        update.tag = lookup_tag;
        case (state)
            st_hit_read: update.touch = 1'b1;
            st_hit_write, st_alloc_write: begin
                update.touch     = 1'b1;
                update.set_dirty = 1'b1;
            end
            st_write_back: update.clear_dirty = wb_beat && last_beat;
            st_fill: begin
                update.set_valid = fill_beat && last_beat;
                update.touch     = fill_beat && last_beat;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= st_idle;
            op_write        <= 1'b0;
            beat            <= '0;
            read_ack        <= 1'b0;
            write_ack       <= 1'b0;
            sdram_read_req  <= 1'b0;
            sdram_write_req <= 1'b0;
        end else begin
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (read_req || write_req) begin
                        op_write <= write_req;
                        state    <= st_lookup;
                    end
                end
                st_lookup: begin
                    beat <= '0;
                    if (lookup.hit) begin
                        state <= op_write ? st_hit_write : st_hit_read;
                    end else if (lookup.victim_dirty) begin
                        state <= st_evict_rd;
                    end else begin
                        state <= st_fill_req;
                    end
                end
                st_hit_read: begin
                    read_ack <= 1'b1;
                    state    <= st_idle;
                end
                st_hit_write: begin
                    write_ack <= 1'b1;
                    state     <= st_idle;
                end
                st_evict_rd: begin
                    sdram_write_req <= 1'b1;
                    state           <= st_write_back;
                end
                st_write_back: begin
                    if (wb_beat) begin
                        beat <= beat + word_offset_t'(1);
                        if (last_beat) begin
                            sdram_write_req <= 1'b0;
                            state           <= st_fill_req;
                        end
                    end
                end
                st_fill_req: begin
                    sdram_read_req <= 1'b1;
                    beat           <= '0;
                    state          <= st_fill;
                end
                st_fill: begin
                    if (fill_beat) begin
                        beat <= beat + word_offset_t'(1);
                        if (!op_write && beat == req_word) begin
                            read_ack <= 1'b1;
                        end
                        if (last_beat) begin
                            sdram_read_req <= 1'b0;
                            state          <= op_write ? st_alloc_write : st_idle;
                        end
                    end
                end
                st_alloc_write: begin
                    write_ack <= 1'b1;
                    state     <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address, decision and data registers.
    always_ff @(posedge sys_clk) begin
        case (state)
            st_idle: begin
                if (read_req || write_req) begin
                    addr_r <= address;
                end
            end
            st_lookup: begin
                way_r        <= lookup.hit ? lookup.hit_way : lookup.victim_way;
                victim_tag_r <= lookup.victim_tag;
            end
            st_hit_read: data_read <= pick_byte(ram_q[way_r], addr_r[0]);
            st_evict_rd: sdram_address <= {8'd0, victim_tag_r, lookup_set, 4'd0};
            st_write_back: begin
                if (wb_beat) begin
                    sdram_address <= sdram_address + sdram_addr_t'(1);
                end
            end
            st_fill_req: sdram_address <= {8'd0, lookup_tag, lookup_set, 4'd0};
            st_fill: begin
                if (fill_beat) begin
                    sdram_address <= sdram_address + sdram_addr_t'(1);
                    if (!op_write && beat == req_word) begin
                        data_read <= pick_byte(sdram_data_read, addr_r[0]);
                    end
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge sys_clk) disable iff (!reset_n) !(read_req && write_req))
        else $error("controller: read_req and write_req high together");

    // the write-back must finish before the fill of the same victim starts.
    assert property (@(posedge sys_clk) disable iff (!reset_n)
                     !(sdram_read_req && sdram_write_req))
        else $error("controller: sdram_read_req and sdram_write_req high together");

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

    // ------------------------------------------------------------
    // cache geometry
    // ------------------------------------------------------------
    localparam int cache_ways = 2;
    localparam int cache_sets = 16;
    localparam int line_words = 16;

    typedef logic [16:0] byte_addr_t;
    typedef logic [7:0]  tag_t;
    typedef logic [3:0]  set_index_t;
    typedef logic [3:0]  word_offset_t;
    typedef logic [7:0]  ram_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic        way_t;

    // zero, tag, set and word from the top down.
    typedef logic [23:0] sdram_addr_t;

    // ------------------------------------------------------------
    // interfaces between the blocks
    // ------------------------------------------------------------
    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } tag_lookup_t;

    typedef struct packed {
        logic set_valid;
        logic set_dirty;
        logic clear_dirty;
        logic touch;
        way_t way;
        tag_t tag;
    } tag_update_t;

    // byte_en[1] covers the upper byte, which is byte 0 of a word.
    typedef struct packed {
        ram_addr_t   addr;
        word_t       wdata;
        logic [1:0]  byte_en;
    } way_ram_req_t;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_hit_read,
        st_hit_write,
        st_evict_rd,
        st_write_back,
        st_fill_req,
        st_fill,
        st_alloc_write
    } ctrl_state_t;

endpackage

// File: verilog/cache_tag_store.sv
`timescale 1ns/10ps

module cache_tag_store
    import cache_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset_n,
    input  set_index_t  lookup_set,
    input  tag_t        lookup_tag,
    output tag_lookup_t lookup,
    input  tag_update_t update
);

    tag_t                                  tags [cache_ways][cache_sets];
    logic [cache_sets-1:0][cache_ways-1:0] valid;
    logic [cache_sets-1:0][cache_ways-1:0] dirty;
    // the most recently used way of each set.
    way_t                                  mru [cache_sets];
    logic [cache_ways-1:0]                 hit_vec;

    // ------------------------------------------------------------
    // compare and victim choice
    // ------------------------------------------------------------
    always_comb begin
        lookup = '0;
        for (int w = 0; w < cache_ways; w++) begin
            hit_vec[w] = valid[lookup_set][w] && (tags[w][lookup_set] == lookup_tag);
            if (hit_vec[w]) begin
                lookup.hit     = 1'b1;
                lookup.hit_way = way_t'(w);
            end
        end

        // an empty way is taken before anything gets evicted, way 0 first.
        if (!valid[lookup_set][0]) begin
            lookup.victim_way = way_t'(0);
        end else if (!valid[lookup_set][1]) begin
            lookup.victim_way = way_t'(1);
        end else begin
            lookup.victim_way = ~mru[lookup_set];
        end

        lookup.victim_dirty = dirty[lookup_set][lookup.victim_way];
        lookup.victim_tag   = tags[lookup.victim_way][lookup_set];
    end

    // ------------------------------------------------------------
    // state updates
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            valid <= '0;
            dirty <= '0;
            mru   <= '{default: '0};
        end else begin
            if (update.set_valid) begin
                valid[lookup_set][update.way] <= 1'b1;
            end
            if (update.set_dirty) begin
                dirty[lookup_set][update.way] <= 1'b1;
            end else if (update.clear_dirty) begin
                dirty[lookup_set][update.way] <= 1'b0;
            end
            if (update.touch) begin
                mru[lookup_set] <= update.way;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (update.set_valid) begin
            tags[update.way][lookup_set] <= update.tag;
        end
    end

    // a fill only ever goes to the victim, so a line can never live in both ways.
    assert property (@(posedge sys_clk) disable iff (!reset_n) !(&hit_vec))
        else $error("tag store: tag %h hits in both ways of set %0d", lookup_tag, lookup_set);

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset_n,
    input  byte_addr_t  address,
    input  byte_t       data_write,
    input  logic        read_req,
    input  logic        write_req,
    output byte_t       data_read,
    output logic        read_ack,
    output logic        write_ack,
    output sdram_addr_t sdram_address,
    output word_t       sdram_data_write,
    input  word_t       sdram_data_read,
    output logic        sdram_read_req,
    output logic        sdram_write_req,
    input  logic        sdram_read_ack,
    input  logic        sdram_write_ack
);

    set_index_t            lookup_set;
    tag_t                  lookup_tag;
    tag_lookup_t           lookup;
    tag_update_t           update;
    way_ram_req_t          ram_req;
    logic [cache_ways-1:0] ram_wr_en;
    word_t                 ram_q [cache_ways];

    cache_controller u_ctrl (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .address          (address),
        .data_write       (data_write),
        .read_req         (read_req),
        .write_req        (write_req),
        .data_read        (data_read),
        .read_ack         (read_ack),
        .write_ack        (write_ack),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack),
        .lookup_set       (lookup_set),
        .lookup_tag       (lookup_tag),
        .lookup           (lookup),
        .update           (update),
        .ram_req          (ram_req),
        .ram_wr_en        (ram_wr_en),
        .ram_q            (ram_q)
    );

    cache_tag_store u_tags (
        .sys_clk    (sys_clk),
        .reset_n    (reset_n),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .lookup     (lookup),
        .update     (update)
    );

    // every way sees the same request and only its own write enable.
    for (genvar w = 0; w < cache_ways; w++) begin : g_way
        cache_way_ram u_ram (
            .sys_clk (sys_clk),
            .ram_req (ram_req),
            .wr_en   (ram_wr_en[w]),
            .q       (ram_q[w])
        );
    end

endmodule

// File: verilog/cache_way_ram.sv
`timescale 1ns/10ps

module cache_way_ram
    import cache_pkg::*;
(
    input  logic         sys_clk,
    input  way_ram_req_t ram_req,
    input  logic         wr_en,
    output word_t        q
);

    localparam int ram_depth = 2 ** $bits(ram_addr_t);

    word_t mem [ram_depth];

    // the read sees the old word when the same address is written.
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            if (ram_req.byte_en[1]) begin
                mem[ram_req.addr][15:8] <= ram_req.wdata[15:8];
            end
            if (ram_req.byte_en[0]) begin
                mem[ram_req.addr][7:0] <= ram_req.wdata[7:0];
            end
        end
        q <= mem[ram_req.addr];
    end

endmodule
